//--- include/lane_seq_settings.svh
`ifndef LANE_SEQ_SETTINGS_SVH
`define LANE_SEQ_SETTINGS_SVH

// Number of lanes in the machine
// The split logic assumes a power of two
`define LANE_SEQ_NR_LANES 4

// Instruction ids that can be in flight at the same time
`define LANE_SEQ_NR_VINSN 8

// Width of vl and vstart
`define LANE_SEQ_VL_W 16

// Widest element in bits
`define LANE_SEQ_ELEN 64

// Architectural register that holds the mask
`define LANE_SEQ_VMASK 0

`endif

//--- lane_seq.f
+incdir+include
rtl/lane_seq_pkg.sv
rtl/lane_vl_split.sv
rtl/lane_opreq_builder.sv
rtl/lane_opreq_slot.sv
rtl/lane_seq_ctrl.sv
rtl/lane_seq_top.sv
verif/tb_lane_seq.sv

//--- rtl/lane_opreq_builder.sv
`timescale 1ns/10ps
`include "lane_seq_settings.svh"

module lane_opreq_builder import lane_seq_pkg::*; (
  input  vinsn_id_t                  pe_req_id_i,
  input  vfu_e                       pe_req_vfu_i,
  input  vreg_t                      pe_req_vs1_i,
  input  vreg_t                      pe_req_vs2_i,
  input  logic                       pe_req_vm_i,
  input  logic                       pe_req_use_vs1_i,
  input  logic                       pe_req_use_vs2_i,
  input  ew_e                        pe_req_vsew_i,
  input  ew_e                        pe_req_eew_vs1_i,
  input  ew_e                        pe_req_eew_vs2_i,
  input  vinsn_vec_t                 pe_req_hazard_vs1_i,
  input  vinsn_vec_t                 pe_req_hazard_vs2_i,
  input  vinsn_vec_t                 pe_req_hazard_vm_i,
  input  vinsn_vec_t                 pe_req_hazard_vd_i,
  input  logic                       accept_i,
  input  vlen_t                      lane_vstart_i,
  input  vlen_t                      lane_vl_i,
  input  vlen_t                      mask_vl_i,
  input  vlen_t                      store_vl_i,
  output logic [NR_OPQUEUES-1:0]     push_o,
  output vinsn_id_t                  cmd_id_o     [NR_OPQUEUES],
  output vreg_t                      cmd_vs_o     [NR_OPQUEUES],
  output ew_e                        cmd_eew_o    [NR_OPQUEUES],
  output vlen_t                      cmd_vl_o     [NR_OPQUEUES],
  output vlen_t                      cmd_vstart_o [NR_OPQUEUES],
  output vinsn_vec_t                 cmd_hazard_o [NR_OPQUEUES]
);

  // Push requests before acceptance is known
  logic [NR_OPQUEUES-1:0] push_req;

  always_comb begin
    push_req = '0;
    for (int q = 0; q < NR_OPQUEUES; q++) begin
      cmd_id_o[q]     = pe_req_id_i;
      cmd_vs_o[q]     = '0;
      cmd_eew_o[q]    = EW8;
      cmd_vl_o[q]     = '0;
      cmd_vstart_o[q] = lane_vstart_i;
      cmd_hazard_o[q] = '0;
    end

    case (pe_req_vfu_i)
      VFU_ALU: begin
        cmd_vs_o[OQ_ALU_A]     = pe_req_vs1_i;
        cmd_eew_o[OQ_ALU_A]    = pe_req_eew_vs1_i;
        cmd_vl_o[OQ_ALU_A]     = lane_vl_i;
        cmd_hazard_o[OQ_ALU_A] = pe_req_hazard_vs1_i | pe_req_hazard_vd_i;
        push_req[OQ_ALU_A]     = pe_req_use_vs1_i;

        cmd_vs_o[OQ_ALU_B]     = pe_req_vs2_i;
        cmd_eew_o[OQ_ALU_B]    = pe_req_eew_vs2_i;
        cmd_vl_o[OQ_ALU_B]     = lane_vl_i;
        cmd_hazard_o[OQ_ALU_B] = pe_req_hazard_vs2_i | pe_req_hazard_vd_i;
        push_req[OQ_ALU_B]     = pe_req_use_vs2_i;
      end
      VFU_STORE: begin
        // The store unit collects data from every lane, hence the rounded length
        cmd_vs_o[OQ_ST_A]     = pe_req_vs1_i;
        cmd_eew_o[OQ_ST_A]    = pe_req_eew_vs1_i;
        cmd_vl_o[OQ_ST_A]     = store_vl_i;
        cmd_hazard_o[OQ_ST_A] = pe_req_hazard_vs1_i | pe_req_hazard_vd_i;
        push_req[OQ_ST_A]     = pe_req_use_vs1_i;
      end
      default: begin
      end
    endcase

    // Both classes read the mask register when the instruction is masked
    if (pe_req_vfu_i == VFU_ALU || pe_req_vfu_i == VFU_STORE) begin
      cmd_vs_o[OQ_MASK_M]     = vreg_t'(`LANE_SEQ_VMASK);
      cmd_eew_o[OQ_MASK_M]    = pe_req_vsew_i;
      cmd_vl_o[OQ_MASK_M]     = mask_vl_i;
      cmd_hazard_o[OQ_MASK_M] = pe_req_hazard_vm_i | pe_req_hazard_vd_i;
      push_req[OQ_MASK_M]     = !pe_req_vm_i;
    end
  end

  assign push_o = push_req & {NR_OPQUEUES{accept_i}};

endmodule

//--- rtl/lane_opreq_slot.sv
`timescale 1ns/10ps

module lane_opreq_slot import lane_seq_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       push_i,
  input  vinsn_id_t  id_i,
  input  vreg_t      vs_i,
  input  ew_e        eew_i,
  input  vlen_t      vl_i,
  input  vlen_t      vstart_i,
  input  vinsn_vec_t hazard_i,
  input  logic       ready_i,
  input  vinsn_vec_t vinsn_running_i,
  output logic       valid_o,
  output vinsn_id_t  id_o,
  output vreg_t      vs_o,
  output ew_e        eew_o,
  output vlen_t      vl_o,
  output vlen_t      vstart_o,
  output vinsn_vec_t hazard_o
);

  // A slot cannot be a plain FIFO entry since its hazard bits shrink over time
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_o  <= 1'b0;
      hazard_o <= '0;
    end else begin
      // A new push takes priority over the consumer taking the old command
      if (push_i) begin
        valid_o <= 1'b1;
      end else if (ready_i) begin
        valid_o <= 1'b0;
      end
      hazard_o <= (push_i ? hazard_i : hazard_o) & vinsn_running_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      id_o     <= id_i;
      vs_o     <= vs_i;
      eew_o    <= eew_i;
      vl_o     <= vl_i;
      vstart_o <= vstart_i;
    end
  end

endmodule

//--- rtl/lane_seq_ctrl.sv
`timescale 1ns/10ps

module lane_seq_ctrl import lane_seq_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   pe_req_valid_i,
  input  vinsn_id_t              pe_req_id_i,
  input  vfu_e                   pe_req_vfu_i,
  input  logic                   pe_req_vm_i,
  input  vreg_t                  pe_req_vd_i,
  input  vinsn_vec_t             pe_req_vinsn_running_i,
  input  logic [NR_OPQUEUES-1:0] slot_valid_i,
  input  vlen_t                  lane_vl_i,
  input  vlen_t                  lane_vstart_i,
  input  logic                   alu_ready_i,
  input  vinsn_vec_t             alu_vinsn_done_i,
  output logic                   pe_req_ready_o,
  output logic                   accept_o,
  output logic                   vfu_op_valid_o,
  output vinsn_id_t              vfu_op_id_o,
  output vfu_e                   vfu_op_vfu_o,
  output vlen_t                  vfu_op_vl_o,
  output vlen_t                  vfu_op_vstart_o,
  output logic                   vfu_op_vm_o,
  output vreg_t                  vfu_op_vd_o,
  output vinsn_vec_t             vinsn_running_o,
  output vinsn_vec_t             pe_resp_vinsn_done_o
);

  logic       op_stall;
  logic       slot_busy;
  logic       id_busy;
  vinsn_vec_t running_masked;
  vinsn_vec_t running_d;

  // Only the ALU can push back, any other unit takes the operation at once
  assign op_stall = vfu_op_valid_o && (vfu_op_vfu_o == VFU_ALU) && !alu_ready_i;

  // Instructions retired by the main sequencer drop out of the running set
  assign running_masked = vinsn_running_o & pe_req_vinsn_running_i;

  always_comb begin
    case (pe_req_vfu_i)
      VFU_ALU: begin
        slot_busy = slot_valid_i[OQ_ALU_A] || slot_valid_i[OQ_ALU_B] ||
                    slot_valid_i[OQ_MASK_M];
      end
      VFU_STORE: begin
        slot_busy = slot_valid_i[OQ_ST_A] || slot_valid_i[OQ_MASK_M];
      end
      default: begin
        slot_busy = 1'b0;
      end
    endcase
  end

  // Holding back a request with a running id keeps it from being dropped
  assign id_busy = running_masked[pe_req_id_i];

  assign pe_req_ready_o = !op_stall && !slot_busy && !id_busy;
  assign accept_o       = pe_req_valid_i && pe_req_ready_o;

  always_comb begin
    running_d = running_masked;
    if (accept_o) begin
      running_d[pe_req_id_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vfu_op_valid_o       <= 1'b0;
      vinsn_running_o      <= '0;
      pe_resp_vinsn_done_o <= '0;
    end else begin
      // A stalled operation keeps its valid, otherwise a new one may replace it
      if (!op_stall) begin
        vfu_op_valid_o <= accept_o;
      end
      vinsn_running_o      <= running_d;
      pe_resp_vinsn_done_o <= alu_vinsn_done_i;
    end
  end

  // Acceptance implies no stall, so the fields stay put while the ALU waits
  always_ff @(posedge clk_i) begin
    if (accept_o) begin
      vfu_op_id_o     <= pe_req_id_i;
      vfu_op_vfu_o    <= pe_req_vfu_i;
      vfu_op_vl_o     <= lane_vl_i;
      vfu_op_vstart_o <= lane_vstart_i;
      vfu_op_vm_o     <= pe_req_vm_i;
      vfu_op_vd_o     <= pe_req_vd_i;
    end
  end

endmodule

//--- rtl/lane_seq_pkg.sv
`include "lane_seq_settings.svh"

package lane_seq_pkg;

  // Functional unit that executes an instruction
  typedef enum logic [1:0] {
    VFU_ALU   = 2'd0,
    VFU_STORE = 2'd1,
    VFU_NONE  = 2'd2
  } vfu_e;

  // Element width code, log2 of the width in bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } ew_e;

  // Operand queues served by this lane
  typedef enum logic [1:0] {
    OQ_ALU_A  = 2'd0,
    OQ_ALU_B  = 2'd1,
    OQ_ST_A   = 2'd2,
    OQ_MASK_M = 2'd3
  } opqueue_e;

  localparam int unsigned NR_OPQUEUES = 4;

  // Bits needed to index a lane and log2 of the widest element in bytes
  localparam int unsigned LANES_LOG = $clog2(`LANE_SEQ_NR_LANES);
  localparam int unsigned ELEN_B_LOG = $clog2(`LANE_SEQ_ELEN / 8);

  // Instruction id and one-hot style vector over all ids
  typedef logic [$clog2(`LANE_SEQ_NR_VINSN)-1:0] vinsn_id_t;
  typedef logic [`LANE_SEQ_NR_VINSN-1:0] vinsn_vec_t;

  // Vector length or start index
  typedef logic [`LANE_SEQ_VL_W-1:0] vlen_t;

  // Architectural vector register index
  typedef logic [4:0] vreg_t;

  // Lane number within the machine
  typedef logic [LANES_LOG-1:0] lane_id_t;

endpackage

//--- rtl/lane_seq_top.sv
`timescale 1ns/10ps

module lane_seq_top import lane_seq_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  lane_id_t               lane_id_i,
  input  logic                   pe_req_valid_i,
  input  vinsn_id_t              pe_req_id_i,
  input  vfu_e                   pe_req_vfu_i,
  input  vlen_t                  pe_req_vl_i,
  input  vlen_t                  pe_req_vstart_i,
  input  vreg_t                  pe_req_vs1_i,
  input  vreg_t                  pe_req_vs2_i,
  input  vreg_t                  pe_req_vd_i,
  input  logic                   pe_req_vm_i,
  input  logic                   pe_req_use_vs1_i,
  input  logic                   pe_req_use_vs2_i,
  input  ew_e                    pe_req_vsew_i,
  input  ew_e                    pe_req_eew_vs1_i,
  input  ew_e                    pe_req_eew_vs2_i,
  input  vinsn_vec_t             pe_req_hazard_vs1_i,
  input  vinsn_vec_t             pe_req_hazard_vs2_i,
  input  vinsn_vec_t             pe_req_hazard_vm_i,
  input  vinsn_vec_t             pe_req_hazard_vd_i,
  input  vinsn_vec_t             pe_req_vinsn_running_i,
  input  logic [NR_OPQUEUES-1:0] opreq_ready_i,
  input  logic                   alu_ready_i,
  input  vinsn_vec_t             alu_vinsn_done_i,
  output logic                   pe_req_ready_o,
  output vinsn_vec_t             pe_resp_vinsn_done_o,
  output logic [NR_OPQUEUES-1:0] opreq_valid_o,
  output vinsn_id_t              opreq_id_o     [NR_OPQUEUES],
  output vreg_t                  opreq_vs_o     [NR_OPQUEUES],
  output ew_e                    opreq_eew_o    [NR_OPQUEUES],
  output vlen_t                  opreq_vl_o     [NR_OPQUEUES],
  output vlen_t                  opreq_vstart_o [NR_OPQUEUES],
  output vinsn_vec_t             opreq_hazard_o [NR_OPQUEUES],
  output logic                   vfu_op_valid_o,
  output vinsn_id_t              vfu_op_id_o,
  output vfu_e                   vfu_op_vfu_o,
  output vlen_t                  vfu_op_vl_o,
  output vlen_t                  vfu_op_vstart_o,
  output logic                   vfu_op_vm_o,
  output vreg_t                  vfu_op_vd_o,
  output vinsn_vec_t             vinsn_running_o
);

  logic                   accept;
  vlen_t                  lane_vl;
  vlen_t                  lane_vstart;
  vlen_t                  mask_vl;
  vlen_t                  store_vl;
  logic [NR_OPQUEUES-1:0] push;
  vinsn_id_t              cmd_id     [NR_OPQUEUES];
  vreg_t                  cmd_vs     [NR_OPQUEUES];
  ew_e                    cmd_eew    [NR_OPQUEUES];
  vlen_t                  cmd_vl     [NR_OPQUEUES];
  vlen_t                  cmd_vstart [NR_OPQUEUES];
  vinsn_vec_t             cmd_hazard [NR_OPQUEUES];

  lane_seq_ctrl i_ctrl (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .pe_req_valid_i         (pe_req_valid_i),
    .pe_req_id_i            (pe_req_id_i),
    .pe_req_vfu_i           (pe_req_vfu_i),
    .pe_req_vm_i            (pe_req_vm_i),
    .pe_req_vd_i            (pe_req_vd_i),
    .pe_req_vinsn_running_i (pe_req_vinsn_running_i),
    .slot_valid_i           (opreq_valid_o),
    .lane_vl_i              (lane_vl),
    .lane_vstart_i          (lane_vstart),
    .alu_ready_i            (alu_ready_i),
    .alu_vinsn_done_i       (alu_vinsn_done_i),
    .pe_req_ready_o         (pe_req_ready_o),
    .accept_o               (accept),
    .vfu_op_valid_o         (vfu_op_valid_o),
    .vfu_op_id_o            (vfu_op_id_o),
    .vfu_op_vfu_o           (vfu_op_vfu_o),
    .vfu_op_vl_o            (vfu_op_vl_o),
    .vfu_op_vstart_o        (vfu_op_vstart_o),
    .vfu_op_vm_o            (vfu_op_vm_o),
    .vfu_op_vd_o            (vfu_op_vd_o),
    .vinsn_running_o        (vinsn_running_o),
    .pe_resp_vinsn_done_o   (pe_resp_vinsn_done_o)
  );

  lane_vl_split i_split (
    .lane_id_i       (lane_id_i),
    .pe_req_vl_i     (pe_req_vl_i),
    .pe_req_vstart_i (pe_req_vstart_i),
    .pe_req_vsew_i   (pe_req_vsew_i),
    .lane_vl_o       (lane_vl),
    .lane_vstart_o   (lane_vstart),
    .mask_vl_o       (mask_vl),
    .store_vl_o      (store_vl)
  );

  lane_opreq_builder i_builder (
    .pe_req_id_i         (pe_req_id_i),
    .pe_req_vfu_i        (pe_req_vfu_i),
    .pe_req_vs1_i        (pe_req_vs1_i),
    .pe_req_vs2_i        (pe_req_vs2_i),
    .pe_req_vm_i         (pe_req_vm_i),
    .pe_req_use_vs1_i    (pe_req_use_vs1_i),
    .pe_req_use_vs2_i    (pe_req_use_vs2_i),
    .pe_req_vsew_i       (pe_req_vsew_i),
    .pe_req_eew_vs1_i    (pe_req_eew_vs1_i),
    .pe_req_eew_vs2_i    (pe_req_eew_vs2_i),
    .pe_req_hazard_vs1_i (pe_req_hazard_vs1_i),
    .pe_req_hazard_vs2_i (pe_req_hazard_vs2_i),
    .pe_req_hazard_vm_i  (pe_req_hazard_vm_i),
    .pe_req_hazard_vd_i  (pe_req_hazard_vd_i),
    .accept_i            (accept),
    .lane_vstart_i       (lane_vstart),
    .lane_vl_i           (lane_vl),
    .mask_vl_i           (mask_vl),
    .store_vl_i          (store_vl),
    .push_o              (push),
    .cmd_id_o            (cmd_id),
    .cmd_vs_o            (cmd_vs),
    .cmd_eew_o           (cmd_eew),
    .cmd_vl_o            (cmd_vl),
    .cmd_vstart_o        (cmd_vstart),
    .cmd_hazard_o        (cmd_hazard)
  );

  // One request slot per operand queue, indexed by opqueue_e
  for (genvar q = 0; q < NR_OPQUEUES; q++) begin : gen_slot
    lane_opreq_slot i_slot (
      .clk_i           (clk_i),
      .rst_ni          (rst_ni),
      .push_i          (push[q]),
      .id_i            (cmd_id[q]),
      .vs_i            (cmd_vs[q]),
      .eew_i           (cmd_eew[q]),
      .vl_i            (cmd_vl[q]),
      .vstart_i        (cmd_vstart[q]),
      .hazard_i        (cmd_hazard[q]),
      .ready_i         (opreq_ready_i[q]),
      .vinsn_running_i (pe_req_vinsn_running_i),
      .valid_o         (opreq_valid_o[q]),
      .id_o            (opreq_id_o[q]),
      .vs_o            (opreq_vs_o[q]),
      .eew_o           (opreq_eew_o[q]),
      .vl_o            (opreq_vl_o[q]),
      .vstart_o        (opreq_vstart_o[q]),
      .hazard_o        (opreq_hazard_o[q])
    );
  end

endmodule

//--- rtl/lane_vl_split.sv
`timescale 1ns/10ps

module lane_vl_split import lane_seq_pkg::*; (
  input  lane_id_t lane_id_i,
  input  vlen_t    pe_req_vl_i,
  input  vlen_t    pe_req_vstart_i,
  input  ew_e      pe_req_vsew_i,
  output vlen_t    lane_vl_o,
  output vlen_t    lane_vstart_o,
  output vlen_t    mask_vl_o,
  output vlen_t    store_vl_o
);

  // Lanes below the remainder take one element more of vl
  logic  vl_extra;
  logic  vstart_extra;
  int    mask_shift;
  vlen_t mask_rem;
  vlen_t store_rem;

  assign vl_extra     = lane_id_i < pe_req_vl_i[LANES_LOG-1:0];
  assign vstart_extra = lane_id_i < pe_req_vstart_i[LANES_LOG-1:0];

  assign lane_vl_o     = (pe_req_vl_i >> LANES_LOG) + vlen_t'(vl_extra);
  // Wraps around when vstart is below the lane count and this lane is early
  assign lane_vstart_o = (pe_req_vstart_i >> LANES_LOG) - vlen_t'(vstart_extra);

  // Store requests leave the lane, so round up instead of splitting exactly
  assign store_rem  = pe_req_vl_i & vlen_t'(`LANE_SEQ_NR_LANES - 1);
  assign store_vl_o = (pe_req_vl_i >> LANES_LOG) + vlen_t'(store_rem != '0);

  // One mask byte per lane covers eight elements, packed by element width
  assign mask_shift = int'(LANES_LOG) + 3 + int'(ELEN_B_LOG) - int'(pe_req_vsew_i);

  always_comb begin
    mask_rem  = pe_req_vl_i & ((vlen_t'(1) << mask_shift) - vlen_t'(1));
    mask_vl_o = (pe_req_vl_i >> mask_shift) + vlen_t'(mask_rem != '0);
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and search the log for the pass line
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_lane_seq -f lane_seq.f \
  && ./obj_dir/Vtb_lane_seq | tee sim.log
grep -qx '\*\* PASS \*\*' sim.log && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

//--- verif/tb_lane_seq.sv
`timescale 1ns/10ps
`include "lane_seq_settings.svh"

module tb_lane_seq import lane_seq_pkg::*; ();

  localparam int unsigned NUM_REQS   = 400;
  localparam int unsigned MAX_CYCLES = NUM_REQS * 25;
  localparam int unsigned NR_LANES   = `LANE_SEQ_NR_LANES;
  localparam int unsigned LANE_NUM   = 2;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic pe_req_valid_i;
  vinsn_id_t pe_req_id_i;
  vfu_e pe_req_vfu_i;
  vlen_t pe_req_vl_i;
  vlen_t pe_req_vstart_i;
  vreg_t pe_req_vs1_i;
  vreg_t pe_req_vs2_i;
  vreg_t pe_req_vd_i;
  logic pe_req_vm_i;
  logic pe_req_use_vs1_i;
  logic pe_req_use_vs2_i;
  ew_e pe_req_vsew_i;
  ew_e pe_req_eew_vs1_i;
  ew_e pe_req_eew_vs2_i;
  vinsn_vec_t pe_req_hazard_vs1_i;
  vinsn_vec_t pe_req_hazard_vs2_i;
  vinsn_vec_t pe_req_hazard_vm_i;
  vinsn_vec_t pe_req_hazard_vd_i;
  vinsn_vec_t pe_req_vinsn_running_i;
  logic [NR_OPQUEUES-1:0] opreq_ready_i;
  logic alu_ready_i;
  vinsn_vec_t alu_vinsn_done_i;

  logic pe_req_ready_o;
  vinsn_vec_t pe_resp_vinsn_done_o;
  logic [NR_OPQUEUES-1:0] opreq_valid_o;
  vinsn_id_t opreq_id_o [NR_OPQUEUES];
  vreg_t opreq_vs_o [NR_OPQUEUES];
  ew_e opreq_eew_o [NR_OPQUEUES];
  vlen_t opreq_vl_o [NR_OPQUEUES];
  vlen_t opreq_vstart_o [NR_OPQUEUES];
  vinsn_vec_t opreq_hazard_o [NR_OPQUEUES];
  logic vfu_op_valid_o;
  vinsn_id_t vfu_op_id_o;
  vfu_e vfu_op_vfu_o;
  vlen_t vfu_op_vl_o;
  vlen_t vfu_op_vstart_o;
  logic vfu_op_vm_o;
  vreg_t vfu_op_vd_o;
  vinsn_vec_t vinsn_running_o;

  // Reference model state, always one edge ahead of the next check
  logic m_op_valid;
  vinsn_id_t m_op_id;
  vfu_e m_op_vfu;
  vlen_t m_op_vl;
  vlen_t m_op_vstart;
  logic m_op_vm;
  vreg_t m_op_vd;
  vinsn_vec_t m_running;
  vinsn_vec_t m_done;
  logic m_sv [NR_OPQUEUES];
  vinsn_id_t m_sid [NR_OPQUEUES];
  vreg_t m_svs [NR_OPQUEUES];
  ew_e m_seew [NR_OPQUEUES];
  vlen_t m_svl [NR_OPQUEUES];
  vlen_t m_svst [NR_OPQUEUES];
  vinsn_vec_t m_shz [NR_OPQUEUES];

  logic [31:0] rng_state;
  int unsigned accepted;
  int unsigned cycles;
  logic took;

  always #4 clk_i = ~clk_i;

  lane_seq_top i_lane_seq_top (.lane_id_i(lane_id_t'(LANE_NUM)), .*);

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    logic [31:0] r;
    r = next_rand();
    return (r >> 8) % n;
  endfunction

  // The low lanes take the remainder of vl as one extra element each
  function automatic vlen_t share_vl(input int unsigned vl);
    int unsigned share;
    share = vl / NR_LANES;
    if (LANE_NUM < vl % NR_LANES) share = share + 1;
    return vlen_t'(share);
  endfunction

  function automatic vlen_t share_vstart(input int unsigned vstart);
    int unsigned share;
    share = vstart / NR_LANES;
    if (LANE_NUM < vstart % NR_LANES) share = share - 1;
    return vlen_t'(share);
  endfunction

  // Elements covered per mask element grow as the element width shrinks
  function automatic vlen_t mask_len(input int unsigned vl, input int unsigned vsew);
    int unsigned div;
    div = NR_LANES * 8 * (1 << (3 - vsew));
    return vlen_t'((vl + div - 1) / div);
  endfunction

  function automatic vlen_t store_len(input int unsigned vl);
    return vlen_t'((vl + NR_LANES - 1) / NR_LANES);
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at time %0t: %s is %0h, expected %0h", $time, what, actual,
               expected);
      $display("** FAIL **");
      $fatal(1, "Output mismatch on %s", what);
    end
  endtask

  task automatic compare_outputs();
    check_value(32'(vfu_op_valid_o), 32'(m_op_valid), "vfu_op_valid_o");
    if (m_op_valid) begin
      check_value(32'(vfu_op_id_o), 32'(m_op_id), "vfu_op_id_o");
      check_value(32'(vfu_op_vfu_o), 32'(m_op_vfu), "vfu_op_vfu_o");
      check_value(32'(vfu_op_vl_o), 32'(m_op_vl), "vfu_op_vl_o");
      check_value(32'(vfu_op_vstart_o), 32'(m_op_vstart), "vfu_op_vstart_o");
      check_value(32'(vfu_op_vm_o), 32'(m_op_vm), "vfu_op_vm_o");
      check_value(32'(vfu_op_vd_o), 32'(m_op_vd), "vfu_op_vd_o");
    end
    check_value(32'(vinsn_running_o), 32'(m_running), "vinsn_running_o");
    check_value(32'(pe_resp_vinsn_done_o), 32'(m_done), "pe_resp_vinsn_done_o");
    for (int q = 0; q < NR_OPQUEUES; q++) begin
      check_value(32'(opreq_valid_o[q]), 32'(m_sv[q]), $sformatf("opreq_valid_o[%0d]", q));
      check_value(32'(opreq_hazard_o[q]), 32'(m_shz[q]), $sformatf("opreq_hazard_o[%0d]", q));
      if (m_sv[q]) begin
        check_value(32'(opreq_id_o[q]), 32'(m_sid[q]), $sformatf("opreq_id_o[%0d]", q));
        check_value(32'(opreq_vs_o[q]), 32'(m_svs[q]), $sformatf("opreq_vs_o[%0d]", q));
        check_value(32'(opreq_eew_o[q]), 32'(m_seew[q]), $sformatf("opreq_eew_o[%0d]", q));
        check_value(32'(opreq_vl_o[q]), 32'(m_svl[q]), $sformatf("opreq_vl_o[%0d]", q));
        check_value(32'(opreq_vstart_o[q]), 32'(m_svst[q]),
                    $sformatf("opreq_vstart_o[%0d]", q));
      end
    end
  endtask

  task automatic load_slot(input opqueue_e q, input vreg_t vs, input ew_e eew,
                           input vlen_t vl, input vinsn_vec_t hz);
    m_sv[q]   = 1'b1;
    m_sid[q]  = pe_req_id_i;
    m_svs[q]  = vs;
    m_seew[q] = eew;
    m_svl[q]  = vl;
    m_svst[q] = share_vstart(32'(pe_req_vstart_i));
    m_shz[q]  = hz & pe_req_vinsn_running_i;
  endtask

  // Checks ready against the current inputs and advances the model by one edge
  task automatic step_model();
    logic stall;
    logic busy;
    logic ready_exp;
    logic accept;
    vinsn_vec_t live;
    live  = m_running & pe_req_vinsn_running_i;
    stall = m_op_valid && m_op_vfu == VFU_ALU && !alu_ready_i;
    if (pe_req_vfu_i == VFU_ALU) begin
      busy = m_sv[OQ_ALU_A] || m_sv[OQ_ALU_B] || m_sv[OQ_MASK_M];
    end else begin
      busy = m_sv[OQ_ST_A] || m_sv[OQ_MASK_M];
    end
    ready_exp = !stall && !busy && !live[pe_req_id_i];
    check_value(32'(pe_req_ready_o), 32'(ready_exp), "pe_req_ready_o");
    accept = pe_req_valid_i && ready_exp;

    // A push in the same cycle overrides the drain below
    for (int q = 0; q < NR_OPQUEUES; q++) begin
      if (opreq_ready_i[q]) m_sv[q] = 1'b0;
      m_shz[q] = m_shz[q] & pe_req_vinsn_running_i;
    end
    if (accept) begin
      if (pe_req_vfu_i == VFU_ALU) begin
        if (pe_req_use_vs1_i) load_slot(OQ_ALU_A, pe_req_vs1_i, pe_req_eew_vs1_i,
            share_vl(32'(pe_req_vl_i)), pe_req_hazard_vs1_i | pe_req_hazard_vd_i);
        if (pe_req_use_vs2_i) load_slot(OQ_ALU_B, pe_req_vs2_i, pe_req_eew_vs2_i,
            share_vl(32'(pe_req_vl_i)), pe_req_hazard_vs2_i | pe_req_hazard_vd_i);
      end else if (pe_req_use_vs1_i) begin
        load_slot(OQ_ST_A, pe_req_vs1_i, pe_req_eew_vs1_i, store_len(32'(pe_req_vl_i)),
                  pe_req_hazard_vs1_i | pe_req_hazard_vd_i);
      end
      if (!pe_req_vm_i) load_slot(OQ_MASK_M, vreg_t'(`LANE_SEQ_VMASK), pe_req_vsew_i,
          mask_len(32'(pe_req_vl_i), 32'(pe_req_vsew_i)),
          pe_req_hazard_vm_i | pe_req_hazard_vd_i);
      m_op_id     = pe_req_id_i;
      m_op_vfu    = pe_req_vfu_i;
      m_op_vl     = share_vl(32'(pe_req_vl_i));
      m_op_vstart = share_vstart(32'(pe_req_vstart_i));
      m_op_vm     = pe_req_vm_i;
      m_op_vd     = pe_req_vd_i;
      accepted++;
    end
    if (!stall) m_op_valid = accept;
    m_running = live;
    if (accept) m_running[pe_req_id_i] = 1'b1;
    m_done = alu_vinsn_done_i;
    took = accept;
  endtask

  task automatic drive_inputs();
    vinsn_vec_t clear;
    // A pending request keeps its fields until the DUT takes it
    if (took || !pe_req_valid_i) begin
      pe_req_valid_i      <= rand_below(4) != 0;
      pe_req_id_i         <= vinsn_id_t'(rand_below(8));
      pe_req_vfu_i        <= rand_below(2) == 0 ? VFU_ALU : VFU_STORE;
      pe_req_vl_i         <= vlen_t'(rand_below(1024));
      pe_req_vstart_i     <= rand_below(2) == 0 ? vlen_t'(0) : vlen_t'(4 + rand_below(1020));
      pe_req_vs1_i        <= vreg_t'(rand_below(32));
      pe_req_vs2_i        <= vreg_t'(rand_below(32));
      pe_req_vd_i         <= vreg_t'(rand_below(32));
      pe_req_vm_i         <= rand_below(2) == 0;
      pe_req_use_vs1_i    <= rand_below(4) != 0;
      pe_req_use_vs2_i    <= rand_below(4) != 0;
      pe_req_vsew_i       <= ew_e'(rand_below(4));
      pe_req_eew_vs1_i    <= ew_e'(rand_below(4));
      pe_req_eew_vs2_i    <= ew_e'(rand_below(4));
      pe_req_hazard_vs1_i <= vinsn_vec_t'(next_rand() >> 8);
      pe_req_hazard_vs2_i <= vinsn_vec_t'(next_rand() >> 8);
      pe_req_hazard_vm_i  <= vinsn_vec_t'(next_rand() >> 8);
      pe_req_hazard_vd_i  <= vinsn_vec_t'(next_rand() >> 8);
    end
    alu_ready_i   <= rand_below(4) != 0;
    opreq_ready_i <= ~(4'(next_rand() >> 8) & 4'(next_rand() >> 12));
    // Each running id retires with a probability of one in eight
    clear = vinsn_vec_t'((next_rand() >> 8) & (next_rand() >> 8) & (next_rand() >> 8));
    pe_req_vinsn_running_i <= m_running & ~clear;
    alu_vinsn_done_i       <= vinsn_vec_t'(next_rand() >> 8);
  endtask

  initial begin
    rng_state = 32'hb382_3cfe;
    rst_ni = 1'b0;
    pe_req_valid_i = 1'b0;
    pe_req_id_i = '0;
    pe_req_vfu_i = VFU_ALU;
    pe_req_vl_i = '0;
    pe_req_vstart_i = '0;
    pe_req_vs1_i = '0;
    pe_req_vs2_i = '0;
    pe_req_vd_i = '0;
    pe_req_vm_i = 1'b1;
    pe_req_use_vs1_i = 1'b0;
    pe_req_use_vs2_i = 1'b0;
    pe_req_vsew_i = EW8;
    pe_req_eew_vs1_i = EW8;
    pe_req_eew_vs2_i = EW8;
    pe_req_hazard_vs1_i = '0;
    pe_req_hazard_vs2_i = '0;
    pe_req_hazard_vm_i = '0;
    pe_req_hazard_vd_i = '0;
    pe_req_vinsn_running_i = '0;
    opreq_ready_i = '0;
    alu_ready_i = 1'b0;
    alu_vinsn_done_i = '0;
    m_op_valid = 1'b0;
    m_running = '0;
    m_done = '0;
    for (int q = 0; q < NR_OPQUEUES; q++) begin
      m_sv[q] = 1'b0;
      m_shz[q] = '0;
    end
    accepted = 0;
    cycles = 0;
    took = 1'b0;

    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    drive_inputs();
    while (accepted < NUM_REQS) begin
      @(negedge clk_i);
      compare_outputs();
      step_model();
      @(posedge clk_i);
      drive_inputs();
      cycles++;
      if (cycles >= MAX_CYCLES) begin
        $display("Timeout after %0d cycles: the DUT stopped accepting requests, %0d of %0d taken",
                 cycles, accepted, NUM_REQS);
        $display("** FAIL **");
        $fatal(1, "Simulation timed out");
      end
    end
    // The last accepted request shows up on the outputs one edge later
    @(negedge clk_i);
    compare_outputs();
    $display("** PASS **");
    $finish;
  end

endmodule
